/* verilog/cache_pkg.sv */
// cache geometry, address union and line bus types, imported by every cache module
package cache_pkg;

  localparam int ADDR_W         = 12;  // word address
  localparam int OFF_W          = 2;
  localparam int IDX_W          = 2;
  localparam int TAG_W          = ADDR_W - IDX_W - OFF_W;
  localparam int WORDS_PER_LINE = 1 << OFF_W;
  localparam int NUM_LINES      = 1 << IDX_W;
  localparam int DATA_W         = 32;
  localparam int BCNT_W         = OFF_W + 1;  // holds WORDS_PER_LINE

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic [OFF_W-1:0] off;
  } cache_addr_t;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    cache_addr_t       f;
  } cache_addr_u;

  // one word written into a line, gated per line by its enable
  typedef struct packed {
    logic [OFF_W-1:0]  off;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
    logic              valid;
    logic              dirty;
  } line_wr_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic              valid;
    logic              dirty;
    logic [DATA_W-1:0] data;  // word at the lookup offset
  } line_stat_t;

endpackage

/* verilog/cache_line.sv */
// one direct-mapped cache line with two lookup ports and one write port, replicated per index
`timescale 1ns/100ps

module cache_line (
  input  logic                            clk,
  input  logic                            rst_n,
  input  cache_pkg::cache_addr_u          look_a_i,
  input  cache_pkg::cache_addr_u          look_b_i,
  input  logic [cache_pkg::OFF_W-1:0]     wb_off_i,
  input  logic                            we_i,
  input  cache_pkg::line_wr_t             wr_i,
  output cache_pkg::line_stat_t           stat_a_o,
  output cache_pkg::line_stat_t           stat_b_o,
  output logic [cache_pkg::DATA_W-1:0]    wb_data_o
);

  import cache_pkg::*;

  logic [DATA_W-1:0] words_q [WORDS_PER_LINE];
  logic [TAG_W-1:0]  tag_q;
  logic              valid_q;
  logic              dirty_q;

  // valid only rises with the last refill word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else if (we_i) begin
      valid_q <= wr_i.valid;
      dirty_q <= wr_i.dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      words_q[wr_i.off] <= wr_i.data;
      tag_q             <= wr_i.tag;  // same tag on every word of a fill
    end
  end

  always_comb begin
    stat_a_o.tag   = tag_q;
    stat_a_o.valid = valid_q;
    stat_a_o.dirty = dirty_q;
    stat_a_o.data  = words_q[look_a_i.f.off];
  end

  always_comb begin
    stat_b_o.tag   = tag_q;
    stat_b_o.valid = valid_q;
    stat_b_o.dirty = dirty_q;
    stat_b_o.data  = words_q[look_b_i.f.off];
  end

  assign wb_data_o = words_q[wb_off_i];  // write-back beat word

endmodule

/* verilog/miss_controller.sv */
// miss FSM for the cache: victim write-back, line refill and port A write routing into the lines
`timescale 1ns/100ps

module miss_controller (
  input  logic                               clk,
  input  logic                               rst_n,
  input  cache_pkg::cache_addr_u             a_addr_i,
  input  cache_pkg::cache_addr_u             b_addr_i,
  input  logic                               a_write_i,
  input  logic [cache_pkg::DATA_W-1:0]       a_wdata_i,
  input  logic                               a_hit_i,
  input  logic                               a_miss_i,
  input  logic                               b_miss_i,
  input  logic [cache_pkg::TAG_W-1:0]        victim_tag_i,
  input  logic                               victim_dirty_i,
  input  logic [cache_pkg::DATA_W-1:0]       victim_data_i,
  output logic [cache_pkg::IDX_W-1:0]        victim_idx_o,
  output logic [cache_pkg::OFF_W-1:0]        wb_off_o,
  output logic                               busy_o,
  output logic [cache_pkg::NUM_LINES-1:0]    line_we_o,
  output cache_pkg::line_wr_t                line_wr_o,
  output cache_pkg::cache_addr_u             m_addr_o,
  output logic                               m_read_o,
  output logic                               m_write_o,
  output logic [cache_pkg::DATA_W-1:0]       m_wdata_o,
  output logic [cache_pkg::BCNT_W-1:0]       m_burstcount_o,
  input  logic [cache_pkg::DATA_W-1:0]       m_rdata_i,
  input  logic                               m_wait_i,
  input  logic                               m_rvalid_i
);

  import cache_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WB,
    S_FILL
  } state_t;

  state_t      state_q;
  logic [OFF_W-1:0] off_q;  // beat / refill word counter
  logic        m_read_q;
  logic        m_write_q;
  cache_addr_u m_addr_q;
  cache_addr_u miss_addr_q;
  cache_addr_u miss_addr;
  logic        miss_seen;
  logic        last_word;
  logic        a_wr_hit;
  logic        wb_need;

  // live miss address in idle, port A first
  assign miss_addr.raw = (state_q != S_IDLE) ? miss_addr_q.raw :
                         a_miss_i ? a_addr_i.raw : b_addr_i.raw;
  assign miss_seen     = a_miss_i || b_miss_i;
  assign last_word     = off_q == OFF_W'(WORDS_PER_LINE - 1);
  assign a_wr_hit      = (state_q == S_IDLE) && a_write_i && a_hit_i;

  assign victim_idx_o = miss_addr.f.idx;
  assign wb_off_o     = off_q;
  assign busy_o       = state_q != S_IDLE;

  // a write landing in the victim on the capture edge makes it dirty too
  assign wb_need = victim_dirty_i || line_we_o[victim_idx_o];

  always_comb begin
    line_we_o = '0;
    if (state_q == S_FILL) begin
      line_wr_o.off   = off_q;
      line_wr_o.tag   = miss_addr_q.f.tag;
      line_wr_o.data  = m_rdata_i;
      line_wr_o.valid = last_word;
      line_wr_o.dirty = 1'b0;
      line_we_o[miss_addr_q.f.idx] = m_rvalid_i;
    end else begin
      line_wr_o.off   = a_addr_i.f.off;
      line_wr_o.tag   = a_addr_i.f.tag;
      line_wr_o.data  = a_wdata_i;
      line_wr_o.valid = 1'b1;
      line_wr_o.dirty = 1'b1;
      line_we_o[a_addr_i.f.idx] = a_wr_hit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= S_IDLE;
      off_q        <= '0;
      m_read_q     <= 1'b0;
      m_write_q    <= 1'b0;
      m_addr_q.raw <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (miss_seen) begin
            m_addr_q.f.idx <= miss_addr.f.idx;
            m_addr_q.f.off <= '0;  // bursts are line aligned
            if (wb_need) begin
              state_q        <= S_WB;
              m_write_q      <= 1'b1;
              m_addr_q.f.tag <= victim_tag_i;
            end else begin
              state_q        <= S_FILL;
              m_read_q       <= 1'b1;
              m_addr_q.f.tag <= miss_addr.f.tag;
            end
          end
        end
        S_WB: begin
          if (!m_wait_i) begin
            if (last_word) begin
              off_q          <= '0;
              m_write_q      <= 1'b0;
              m_read_q       <= 1'b1;
              m_addr_q.f.tag <= miss_addr_q.f.tag;
              state_q        <= S_FILL;
            end else begin
              off_q <= off_q + 1'b1;
            end
          end
        end
        S_FILL: begin
          if (m_read_q && !m_wait_i) begin
            m_read_q <= 1'b0;  // command taken, data follows
          end
          if (m_rvalid_i) begin
            if (last_word) begin
              off_q   <= '0;
              state_q <= S_IDLE;
            end else begin
              off_q <= off_q + 1'b1;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE) begin
      miss_addr_q <= miss_addr;
    end
  end

  assign m_addr_o       = m_addr_q;
  assign m_read_o       = m_read_q;
  assign m_write_o      = m_write_q;
  assign m_wdata_o      = victim_data_i;
  assign m_burstcount_o = BCNT_W'(WORDS_PER_LINE);

endmodule

/* verilog/hit_select.sv */
// picks the indexed line per port, forms hit, readdata and wait, and muxes victim status
`timescale 1ns/100ps

module hit_select (
  input  cache_pkg::cache_addr_u                                a_addr_i,
  input  cache_pkg::cache_addr_u                                b_addr_i,
  input  logic                                                  a_read_i,
  input  logic                                                  a_write_i,
  input  logic                                                  b_read_i,
  input  logic                                                  busy_i,
  input  cache_pkg::line_stat_t [cache_pkg::NUM_LINES-1:0]      stat_a_i,
  input  cache_pkg::line_stat_t [cache_pkg::NUM_LINES-1:0]      stat_b_i,
  input  logic [cache_pkg::NUM_LINES-1:0][cache_pkg::DATA_W-1:0] wb_data_i,
  input  logic [cache_pkg::IDX_W-1:0]                           victim_idx_i,
  output logic                                                  a_hit_o,
  output logic                                                  b_hit_o,
  output logic [cache_pkg::DATA_W-1:0]                          a_rdata_o,
  output logic [cache_pkg::DATA_W-1:0]                          b_rdata_o,
  output logic                                                  a_wait_o,
  output logic                                                  b_wait_o,
  output logic [cache_pkg::TAG_W-1:0]                           victim_tag_o,
  output logic                                                  victim_dirty_o,
  output logic [cache_pkg::DATA_W-1:0]                          victim_data_o
);

  import cache_pkg::*;

  line_stat_t sel_a;
  line_stat_t sel_b;

  assign sel_a = stat_a_i[a_addr_i.f.idx];
  assign sel_b = stat_b_i[b_addr_i.f.idx];

  assign a_hit_o = sel_a.valid && (sel_a.tag == a_addr_i.f.tag);
  assign b_hit_o = sel_b.valid && (sel_b.tag == b_addr_i.f.tag);

  assign a_rdata_o = sel_a.data;
  assign b_rdata_o = sel_b.data;

  // port A writes also hold off while a miss owns the line write port
  assign a_wait_o = (a_read_i && !a_hit_o) || (a_write_i && (!a_hit_o || busy_i));
  assign b_wait_o = b_read_i && !b_hit_o;

  assign victim_tag_o   = stat_a_i[victim_idx_i].tag;  // tag and dirty are per line
  assign victim_dirty_o = stat_a_i[victim_idx_i].dirty;
  assign victim_data_o  = wb_data_i[victim_idx_i];

endmodule

/* verilog/cache_top.sv */
// two-port write-back cache top, joins the miss FSM, the line array and the hit selector
`timescale 1ns/100ps

module cache_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  cache_pkg::cache_addr_u          a_addr_i,
  input  logic                            a_read_i,
  input  logic                            a_write_i,
  input  logic [cache_pkg::DATA_W-1:0]    a_wdata_i,
  output logic [cache_pkg::DATA_W-1:0]    a_rdata_o,
  output logic                            a_wait_o,
  input  cache_pkg::cache_addr_u          b_addr_i,
  input  logic                            b_read_i,
  output logic [cache_pkg::DATA_W-1:0]    b_rdata_o,
  output logic                            b_wait_o,
  output cache_pkg::cache_addr_u          m_addr_o,
  output logic                            m_read_o,
  output logic                            m_write_o,
  output logic [cache_pkg::DATA_W-1:0]    m_wdata_o,
  output logic [cache_pkg::BCNT_W-1:0]    m_burstcount_o,
  input  logic [cache_pkg::DATA_W-1:0]    m_rdata_i,
  input  logic                            m_wait_i,
  input  logic                            m_rvalid_i
);

  import cache_pkg::*;

  line_wr_t                             line_wr;
  logic [NUM_LINES-1:0]                 line_we;
  line_stat_t [NUM_LINES-1:0]           stat_a;
  line_stat_t [NUM_LINES-1:0]           stat_b;
  logic [NUM_LINES-1:0][DATA_W-1:0]     wb_data;
  logic [OFF_W-1:0]                     wb_off;
  logic [IDX_W-1:0]                     victim_idx;
  logic [TAG_W-1:0]                     victim_tag;
  logic                                 victim_dirty;
  logic [DATA_W-1:0]                    victim_data;
  logic                                 a_hit;
  logic                                 b_hit;
  logic                                 a_miss;
  logic                                 b_miss;
  logic                                 busy;

  assign a_miss = (a_read_i || a_write_i) && !a_hit;
  assign b_miss = b_read_i && !b_hit;

  miss_controller controller_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .a_addr_i       (a_addr_i),
    .b_addr_i       (b_addr_i),
    .a_write_i      (a_write_i),
    .a_wdata_i      (a_wdata_i),
    .a_hit_i        (a_hit),
    .a_miss_i       (a_miss),
    .b_miss_i       (b_miss),
    .victim_tag_i   (victim_tag),
    .victim_dirty_i (victim_dirty),
    .victim_data_i  (victim_data),
    .victim_idx_o   (victim_idx),
    .wb_off_o       (wb_off),
    .busy_o         (busy),
    .line_we_o      (line_we),
    .line_wr_o      (line_wr),
    .m_addr_o       (m_addr_o),
    .m_read_o       (m_read_o),
    .m_write_o      (m_write_o),
    .m_wdata_o      (m_wdata_o),
    .m_burstcount_o (m_burstcount_o),
    .m_rdata_i      (m_rdata_i),
    .m_wait_i       (m_wait_i),
    .m_rvalid_i     (m_rvalid_i)
  );

  for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
    cache_line line_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .look_a_i  (a_addr_i),
      .look_b_i  (b_addr_i),
      .wb_off_i  (wb_off),
      .we_i      (line_we[i]),
      .wr_i      (line_wr),
      .stat_a_o  (stat_a[i]),
      .stat_b_o  (stat_b[i]),
      .wb_data_o (wb_data[i])
    );
  end

  hit_select hit_select_inst (
    .a_addr_i       (a_addr_i),
    .b_addr_i       (b_addr_i),
    .a_read_i       (a_read_i),
    .a_write_i      (a_write_i),
    .b_read_i       (b_read_i),
    .busy_i         (busy),
    .stat_a_i       (stat_a),
    .stat_b_i       (stat_b),
    .wb_data_i      (wb_data),
    .victim_idx_i   (victim_idx),
    .a_hit_o        (a_hit),
    .b_hit_o        (b_hit),
    .a_rdata_o      (a_rdata_o),
    .b_rdata_o      (b_rdata_o),
    .a_wait_o       (a_wait_o),
    .b_wait_o       (b_wait_o),
    .victim_tag_o   (victim_tag),
    .victim_dirty_o (victim_dirty),
    .victim_data_o  (victim_data)
  );

endmodule

/* verification/cache_sva.sv */
// memory master protocol checks, bound into cache_top
`timescale 1ns/100ps

module cache_sva (
  input logic                         clk,
  input logic                         rst_n,
  input cache_pkg::cache_addr_u       m_addr_o,
  input logic                         m_read_o,
  input logic                         m_write_o,
  input logic [cache_pkg::DATA_W-1:0] m_wdata_o,
  input logic [cache_pkg::BCNT_W-1:0] m_burstcount_o,
  input logic                         m_wait_i
);

  import cache_pkg::*;

  no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(m_read_o && m_write_o)) else $error("read and write strobes high together");

  line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (m_read_o || m_write_o) |-> (m_addr_o.f.off == '0)) else $error("burst address not aligned");

  burst_len: assert property (@(posedge clk) disable iff (!rst_n)
    m_burstcount_o == BCNT_W'(WORDS_PER_LINE)) else $error("wrong burst count");

  // held steady through a stall
  hold_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
    ((m_read_o || m_write_o) && m_wait_i) |=> ($stable(m_addr_o) && $stable(m_read_o)
      && $stable(m_write_o) && $stable(m_wdata_o))) else $error("master changed under wait");

endmodule

bind cache_top cache_sva cache_sva_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .m_addr_o       (m_addr_o),
  .m_read_o       (m_read_o),
  .m_write_o      (m_write_o),
  .m_wdata_o      (m_wdata_o),
  .m_burstcount_o (m_burstcount_o),
  .m_wait_i       (m_wait_i)
);

/* verification/cache_tb.sv */
// testbench for cache_top: burst memory model, shadow memory, directed and random traffic
`timescale 1ns/100ps

module cache_tb;

  import cache_pkg::*;

  localparam int SEED     = 12608;
  localparam int RD_LAT   = 3;                        // memory read latency in cycles
  localparam int OPS      = 300;
  localparam int MISS_CYC = 64;                       // worst write-back plus refill
  localparam int WATCH_NS = (2 * OPS + 20) * MISS_CYC * 8;

  logic              clk;
  logic              rst_n;
  cache_addr_u       a_addr_i;
  logic              a_read_i;
  logic              a_write_i;
  logic [DATA_W-1:0] a_wdata_i;
  logic [DATA_W-1:0] a_rdata_o;
  logic              a_wait_o;
  cache_addr_u       b_addr_i;
  logic              b_read_i;
  logic [DATA_W-1:0] b_rdata_o;
  logic              b_wait_o;
  cache_addr_u       m_addr_o;
  logic              m_read_o;
  logic              m_write_o;
  logic [DATA_W-1:0] m_wdata_o;
  logic [BCNT_W-1:0] m_burstcount_o;
  logic [DATA_W-1:0] m_rdata_i;
  logic              m_wait_i;
  logic              m_rvalid_i;

  logic [DATA_W-1:0] mem    [1 << ADDR_W];
  logic [DATA_W-1:0] shadow [1 << ADDR_W];
  logic [DATA_W-1:0] a_exp;
  logic [DATA_W-1:0] b_exp;
  logic [OFF_W-1:0]  wr_beat;
  logic [ADDR_W-1:0] rd_base;
  logic [OFF_W-1:0]  rd_beat;
  int                rd_left;
  int                rd_delay;
  int                errors;
  int                seed;
  int                stall_seed;
  int                w;
  logic              op_kind [OPS];  // high for a write
  logic [ADDR_W-1:0] op_addr [OPS];
  logic [DATA_W-1:0] op_data [OPS];
  logic [ADDR_W-1:0] b_addr_list [OPS];

  cache_top cache_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // memory model, accepts beats and read commands at the rising edge
  always @(posedge clk) begin
    if (m_write_o && !m_wait_i) begin
      mem[{m_addr_o.f.tag, m_addr_o.f.idx, wr_beat}] = m_wdata_o;
      wr_beat = wr_beat + 1'b1;
    end
    if (m_read_o && !m_wait_i) begin
      rd_base  = m_addr_o.raw;
      rd_beat  = '0;
      rd_left  = WORDS_PER_LINE;
      rd_delay = RD_LAT;
    end else if (rd_left > 0) begin
      if (m_rvalid_i) begin
        rd_beat = rd_beat + 1'b1;
        rd_left = rd_left - 1;
      end else if (rd_delay > 0) begin
        rd_delay = rd_delay - 1;
      end
    end
  end

  always @(negedge clk) begin
    m_wait_i   <= ($random(stall_seed) & 3) == 0;  // random stalls
    m_rvalid_i <= (rd_left > 0) && (rd_delay == 0);
    m_rdata_i  <= mem[rd_base + ADDR_W'(rd_beat)];
  end

  always @(posedge clk) begin
    if (a_write_i && !a_wait_o) shadow[a_addr_i.raw] <= a_wdata_i;
  end

  always_comb a_exp = shadow[a_addr_i.raw];
  always_comb b_exp = shadow[b_addr_i.raw];

  a_read_chk: assert property (@(posedge clk) disable iff (!rst_n)
    (a_read_i && !a_wait_o) |-> (a_rdata_o == a_exp)) else begin
    $display("ERR %0t a_rdata_o got %h expected %h", $time, $sampled(a_rdata_o),
             $sampled(a_exp));
    errors++;
  end

  b_read_chk: assert property (@(posedge clk) disable iff (!rst_n)
    (b_read_i && !b_wait_o) |-> (b_rdata_o == b_exp)) else begin
    $display("ERR %0t b_rdata_o got %h expected %h", $time, $sampled(b_rdata_o),
             $sampled(b_exp));
    errors++;
  end

  // holds the request until accepted, returns the wait cycles
  task automatic access_a(input logic rd, input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, output int waits);
    a_addr_i.raw = addr;
    a_read_i     = rd;
    a_write_i    = wr;
    a_wdata_i    = data;
    waits        = 0;
    #1;
    while (a_wait_o) begin
      @(negedge clk);
      #1;
      waits++;
    end
    @(negedge clk);
    a_read_i  = 1'b0;
    a_write_i = 1'b0;
  endtask

  task automatic read_b(input logic [ADDR_W-1:0] addr);
    b_addr_i.raw = addr;
    b_read_i     = 1'b1;
    #1;
    while (b_wait_o) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    b_read_i = 1'b0;
  endtask

  initial begin
    #WATCH_NS;
    $display("watchdog expired, the cache stopped answering requests");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    seed       = SEED;
    stall_seed = SEED;
    errors     = 0;
    rst_n      = 1'b0;
    a_addr_i   = '0;
    a_read_i   = 1'b0;
    a_write_i  = 1'b0;
    a_wdata_i  = '0;
    b_addr_i   = '0;
    b_read_i   = 1'b0;
    m_rdata_i  = '0;
    m_wait_i   = 1'b0;
    m_rvalid_i = 1'b0;
    wr_beat    = '0;
    rd_base    = '0;
    rd_beat    = '0;
    rd_left    = 0;
    rd_delay   = 0;
    for (int i = 0; i < (1 << ADDR_W); i++) begin
      mem[i]    = i ^ 32'hc3a5_0000;
      shadow[i] = i ^ 32'hc3a5_0000;
    end
    for (int i = 0; i < OPS; i++) begin
      op_kind[i]     = $random(seed);
      op_addr[i]     = $random(seed) & 12'h03f;  // 4 tags per index
      op_data[i]     = $random(seed);
      b_addr_list[i] = $random(seed) & 12'h03f;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    access_a(1'b1, 1'b0, 12'h010, '0, w);
    assert (w > 0) else begin
      $display("first read of 010 did not wait for a refill");
      errors++;
    end
    for (int i = 1; i < WORDS_PER_LINE; i++) begin
      access_a(1'b1, 1'b0, 12'h010 + i, '0, w);
      assert (w == 0) else begin
        $display("read in a refilled line did not hit at once");
        errors++;
      end
    end
    access_a(1'b0, 1'b1, 12'h012, 32'hdead_0012, w);
    access_a(1'b1, 1'b0, 12'h012, '0, w);
    access_a(1'b1, 1'b0, 12'h110, '0, w);  // same index, evicts dirty line
    assert (mem[12'h012] == 32'hdead_0012) else begin
      $display("ERR %0t mem[012] got %h expected %h", $time, mem[12'h012], 32'hdead_0012);
      errors++;
    end
    access_a(1'b1, 1'b0, 12'h012, '0, w);
    assert (w > 0) else begin
      $display("read of 012 after the eviction did not miss");
      errors++;
    end

    fork
      access_a(1'b1, 1'b0, 12'h024, '0, w);
      read_b(12'h038);
    join
    read_b(12'h012);

    fork
      begin
        int wa;
        for (int i = 0; i < OPS; i++) begin
          access_a(!op_kind[i], op_kind[i], op_addr[i], op_data[i], wa);
        end
      end
      begin
        for (int i = 0; i < OPS; i++) read_b(b_addr_list[i]);
      end
    join

    repeat (4) @(negedge clk);
    $display("error count %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* sim.f */
verilog/cache_pkg.sv
verilog/cache_line.sv
verilog/miss_controller.sv
verilog/hit_select.sv
verilog/cache_top.sv
verification/cache_sva.sv
verification/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the cache testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f sim.f

if ! ./obj_dir/Vcache_tb > sim.log 2>&1; then
  cat sim.log
  exit 1
fi
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
grep -q "Done: no errors" sim.log
